//--- ping_vectors.txt
// mask timeout waitmask | alert delays 0..7 | esc delays 0..3 | esc pings status spurious
// delay ff never answers, spurious 1 hits an alert channel and 2 an escalation channel
00ff 0014 000f 0002 0002 0002 0002 0003 0003 0003 0003 0003 0002 0003 0002 0008 0000 0000
0000 0014 000f 0002 0002 0002 0002 0002 0002 0002 0002 0002 0002 0002 0002 0005 0000 0000
00ff 0014 000f 00ff 00ff 00ff 00ff 00ff 00ff 00ff 00ff 0002 0002 0002 0002 0004 0001 0000
00ff 0014 001f 0003 0003 0003 0003 0003 0003 0003 0003 0002 0002 00ff 0002 0004 0002 0000
00ff 0014 000f 0002 0002 0002 0002 0002 0002 0002 0002 0002 0002 0002 0002 0004 0001 0001
00ff 0014 000f 0002 0002 0002 0002 0002 0002 0002 0002 0002 0002 0002 0002 0004 0002 0002

//--- ping.f
ping_pkg.sv
ping_dual_reg.sv
ping_lfsr.sv
ping_timer.sv
ping_apb_regs.sv
ping_top.sv
ping_assert.sv
tb_ping_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the ping checker testbench with Verilator
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal -f ping.f \
       --top-module tb_ping_top -o sim_ping \
  && ./obj_dir/sim_ping \
  || { echo "simulation failed"; exit 1; }

//--- tb_ping_top.sv
// vector-driven testbench of the ping checker
// each line of ping_vectors.txt is one test, run after a fresh reset
// responders answer a fixed number of cycles after they see a request
// needs wait masks of the form 2**n-1 for the watchdog limit to hold
`timescale 1ns/1ps
`default_nettype none

module tb_ping_top;
  import ping_pkg::*;

  localparam int NTests  = 6;
  localparam int NFields = 18;

  logic               clk_i;
  logic               rst_ni;
  apb_req_t           apb_req;
  apb_rsp_t           apb_rsp;
  logic [NAlerts-1:0] alert_ok, alert_req, alert_req_s, spur_alert;
  logic [NEscSev-1:0] esc_ok, esc_req, esc_req_s, spur_esc;
  logic               alert_fail, esc_fail;

  logic [15:0] vec [NTests*NFields];
  logic [15:0] alert_dly [NAlerts];
  logic [15:0] esc_dly [NEscSev];
  logic [15:0] a_cnt [NAlerts];
  logic [15:0] e_cnt [NEscSev];
  logic [NAlerts-1:0] a_done;
  logic [NEscSev-1:0] e_done;
  logic [NAlerts-1:0] cur_mask;
  logic [NEscSev-1:0] esc_prev;
  int                 exp_idx, esc_count, limit_cycles;
  integer             seed;

  ping_top UUT (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .apb_req_i        (apb_req),
    .apb_rsp_o        (apb_rsp),
    .alert_ping_ok_i  (alert_ok),
    .esc_ping_ok_i    (esc_ok),
    .alert_ping_req_o (alert_req),
    .esc_ping_req_o   (esc_req),
    .alert_fail_o     (alert_fail),
    .esc_fail_o       (esc_fail)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  //////////////////////////////
  // checker and bus tasks
  //////////////////////////////

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  // one setup and one access cycle with the response sampled mid access phase
  task automatic apb_xfer(input logic wr, input logic [ApbAw-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    apb_req_t req;
    req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge clk_i);
    apb_req <= req;
    req.penable = 1'b1;
    @(posedge clk_i);
    apb_req <= req;
    @(negedge clk_i);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    check(32'(apb_rsp.pready), 1, "pready in access phase");
    @(posedge clk_i);
    apb_req <= '0;
  endtask

  task automatic reg_write(input logic [ApbAw-1:0] addr, input logic [31:0] wdata);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, addr, wdata, rd, err);
    check(err, 0, "pslverr on mapped write");
  endtask

  task automatic reg_expect(input logic [ApbAw-1:0] addr, input logic [31:0] exp,
                            input string msg);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b0, addr, 32'h0, rd, err);
    check(err, 0, "pslverr on mapped read");
    check(rd, exp, msg);
  endtask

  task automatic reset_dut();
    @(posedge clk_i);
    rst_ni <= 1'b0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
  endtask

  //////////////////////////////
  // responders and monitors
  //////////////////////////////

  // outputs are captured on the falling edge where they are stable
  always @(negedge clk_i) begin
    alert_req_s <= alert_req;
    esc_req_s   <= esc_req;
    if (!rst_ni) begin
      esc_prev  = '0;
      exp_idx   = 0;
      esc_count = 0;
    end else begin
      check(32'(alert_req & ~cur_mask), 0, "request on a masked alert channel");
      if (esc_req != '0 && esc_prev == '0) begin
        check(32'(esc_req), 32'(1 << exp_idx), "escalation round-robin order");
        exp_idx   = (exp_idx + 1) % NEscSev;
        esc_count = esc_count + 1;
      end
      esc_prev = esc_req;
    end
  end

  // each channel answers once per request after its delay and FF stays silent
  always @(posedge clk_i) begin
    logic [NAlerts-1:0] a_nxt;
    logic [NEscSev-1:0] e_nxt;
    a_nxt = '0;
    e_nxt = '0;
    for (int i = 0; i < NAlerts; i++) begin
      if (!alert_req_s[i]) begin
        a_cnt[i]  <= '0;
        a_done[i] <= 1'b0;
      end else if (!a_done[i] && alert_dly[i] != 16'hff && a_cnt[i] == alert_dly[i]) begin
        a_nxt[i]  = 1'b1;
        a_done[i] <= 1'b1;
      end else begin
        a_cnt[i] <= a_cnt[i] + 1'b1;
      end
    end
    for (int i = 0; i < NEscSev; i++) begin
      if (!esc_req_s[i]) begin
        e_cnt[i]  <= '0;
        e_done[i] <= 1'b0;
      end else if (!e_done[i] && esc_dly[i] != 16'hff && e_cnt[i] == esc_dly[i]) begin
        e_nxt[i]  = 1'b1;
        e_done[i] <= 1'b1;
      end else begin
        e_cnt[i] <= e_cnt[i] + 1'b1;
      end
    end
    alert_ok <= a_nxt | spur_alert;
    esc_ok   <= e_nxt | spur_esc;
  end

  initial begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk_i);
    $display("watchdog expired before all tests were done");
    $display("Something failed");
    $fatal(1);
  end

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    logic [31:0] rd;
    logic        err;
    int          base, n_esc, max_esc, max_span, sel;
    logic [15:0] exp_stat, spur;
    rst_ni      = 1'b0;
    apb_req     = '0;
    alert_ok    = '0;
    esc_ok      = '0;
    spur_alert  = '0;
    spur_esc    = '0;
    alert_req_s = '0;
    esc_req_s   = '0;
    cur_mask    = '1;
    seed        = 11592;
    for (int i = 0; i < NAlerts; i++) alert_dly[i] = 16'd0;
    for (int i = 0; i < NEscSev; i++) esc_dly[i] = 16'd0;
    $readmemh("ping_vectors.txt", vec);

    // watchdog budget follows the slowest wait and timeout of all tests
    max_esc  = 0;
    max_span = 0;
    for (int t = 0; t < NTests; t++) begin
      base = t * NFields;
      if (int'(vec[base+15]) > max_esc) max_esc = int'(vec[base+15]);
      if (int'(vec[base+1]) + int'(vec[base+2]) + 4 > max_span)
        max_span = int'(vec[base+1]) + int'(vec[base+2]) + 4;
    end
    limit_cycles = NTests * max_esc * 2 * max_span + 1000;

    // register access checks
    reset_dut();
    reg_expect(RegCtrl, 0, "ctrl after reset");
    reg_expect(RegAlertEn, 0, "alert mask after reset");
    reg_expect(RegTimeout, 0, "timeout after reset");
    reg_expect(RegWaitMask, 0, "wait mask after reset");
    reg_expect(RegStatus, 0, "status after reset");
    reg_write(RegAlertEn, 32'h0000_00a5);
    reg_write(RegTimeout, 32'h0000_1234);
    reg_write(RegWaitMask, 32'h0000_00f0);
    reg_expect(RegAlertEn, 32'h0000_00a5, "alert mask read-back");
    reg_expect(RegTimeout, 32'h0000_1234, "timeout read-back");
    reg_expect(RegWaitMask, 32'h0000_00f0, "wait mask read-back");
    reg_write(RegCtrl, 32'h1);
    reg_write(RegCtrl, 32'h0);
    reg_expect(RegCtrl, 32'h1, "enable stays set");
    apb_xfer(1'b0, 5'h14, 32'h0, rd, err);
    check(err, 1, "pslverr on unmapped address");
    check(rd, 0, "read data of unmapped address");

    for (int t = 0; t < NTests; t++) begin
      base = t * NFields;
      for (int i = 0; i < NAlerts; i++) alert_dly[i] = vec[base+3+i];
      for (int i = 0; i < NEscSev; i++) esc_dly[i] = vec[base+11+i];
      n_esc    = int'(vec[base+15]);
      exp_stat = vec[base+16];
      spur     = vec[base+17];
      cur_mask = vec[base][NAlerts-1:0];
      reset_dut();
      reg_write(RegAlertEn, 32'(vec[base]));
      reg_write(RegTimeout, 32'(vec[base+1]));
      reg_write(RegWaitMask, 32'(vec[base+2]));
      reg_write(RegCtrl, 32'h1);

      // inject while the FSM sits in a long enough wait phase
      if (spur != 0) begin
        do @(negedge clk_i);
        while (!(UUT.u_timer.cnt_q > 4 && alert_req == '0 && esc_req == '0));
        sel = {$random(seed)} % 32'(NAlerts);
        @(posedge clk_i);
        if (spur[0]) spur_alert <= NAlerts'(1 << sel);
        else spur_esc <= NEscSev'(1 << (sel % NEscSev));
        @(posedge clk_i);
        spur_alert <= '0;
        spur_esc   <= '0;
        repeat (2) @(negedge clk_i);
        check(32'({esc_fail, alert_fail}), 32'(spur), "fail output after spurious ok");
      end

      // the monitor counts on the falling edge, so the count is read on the rising one
      do @(posedge clk_i);
      while (esc_count < n_esc);
      reg_expect(RegStatus, 32'(exp_stat), $sformatf("status of test %0d", t));
      check(32'({esc_fail, alert_fail}), 32'(exp_stat), "fail outputs");

      // clear right after a failed alert ping, then wait for the next one
      if (exp_stat[0] && spur == 0) begin
        do @(negedge clk_i);
        while (!UUT.fail.alert_fail);
        reg_write(RegStatus, 32'h1);
        @(negedge clk_i);
        check(32'(alert_fail), 0, "alert fail after clear");
        reg_expect(RegStatus, 0, "status after clear");
        do @(negedge clk_i);
        while (!alert_fail);
      end
    end

    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- ping_assert.sv
// request checks of the ping timer, bound into every ping_timer
// a request may only change in the cycle after an accepted ok or expiry
`timescale 1ns/1ps
`default_nettype none

module ping_assert import ping_pkg::*; (
  input wire               clk_i,
  input wire               rst_ni,
  input wire [NAlerts-1:0] alert_req_i,
  input wire [NEscSev-1:0] esc_req_i,
  input wire [NAlerts-1:0] alert_ok_i,
  input wire [NEscSev-1:0] esc_ok_i,
  input wire               expired_i
);

  a_alert_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(alert_req_i)) else $error("more than one alert request high");

  a_esc_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(esc_req_i)) else $error("more than one escalation request high");

  a_one_kind: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !((|alert_req_i) && (|esc_req_i))) else $error("alert and escalation pinged together");

  a_alert_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((|alert_req_i) && !(|(alert_req_i & alert_ok_i)) && !expired_i)
      |=> (alert_req_i == $past(alert_req_i)))
    else $error("alert request dropped early");

  a_esc_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((|esc_req_i) && !(|(esc_req_i & esc_ok_i)) && !expired_i)
      |=> (esc_req_i == $past(esc_req_i)))
    else $error("escalation request dropped early");

endmodule

bind ping_timer ping_assert u_ping_assert (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .alert_req_i (alert_ping_req_o),
  .esc_req_i   (esc_ping_req_o),
  .alert_ok_i  (alert_ping_ok_i),
  .esc_ok_i    (esc_ping_ok_i),
  .expired_i   (timer_expired)
);

`default_nettype wire

//--- ping_top.sv
// top level of the ping checker
// responders answer on plain ok wires, no alert or escalation handshake
// fail outputs are the sticky status bits and stay high until cleared
`timescale 1ns/1ps
`default_nettype none

module ping_top import ping_pkg::*; (
  input  wire                clk_i,
  input  wire                rst_ni,
  input  apb_req_t           apb_req_i,
  output apb_rsp_t           apb_rsp_o,
  input  wire  [NAlerts-1:0] alert_ping_ok_i,
  input  wire  [NEscSev-1:0] esc_ping_ok_i,
  output logic [NAlerts-1:0] alert_ping_req_o,
  output logic [NEscSev-1:0] esc_ping_req_o,
  output logic               alert_fail_o,
  output logic               esc_fail_o
);

  ping_cfg_t  cfg;
  ping_fail_t fail;

  // configuration and status registers on the APB side
  ping_apb_regs u_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .apb_req_i    (apb_req_i),
    .apb_rsp_o    (apb_rsp_o),
    .fail_i       (fail),
    .cfg_o        (cfg),
    .alert_fail_o (alert_fail_o),
    .esc_fail_o   (esc_fail_o)
  );

  // ping sequencing with its own redundant counters and LFSR
  ping_timer u_timer (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .cfg_i            (cfg),
    .alert_ping_ok_i  (alert_ping_ok_i),
    .esc_ping_ok_i    (esc_ping_ok_i),
    .alert_ping_req_o (alert_ping_req_o),
    .esc_ping_req_o   (esc_ping_req_o),
    .fail_o           (fail)
  );

endmodule

`default_nettype wire

//--- ping_apb_regs.sv
// APB slave holding the ping configuration and the sticky fail status
// pready is tied high, so each transfer takes one setup and one access cycle
// the enable bit can only be set, a reset is the only way to clear it
// a fail pulse wins over a write-one-to-clear in the same cycle
`timescale 1ns/1ps
`default_nettype none

module ping_apb_regs import ping_pkg::*; (
  input  wire        clk_i,
  input  wire        rst_ni,
  input  apb_req_t   apb_req_i,
  output apb_rsp_t   apb_rsp_o,
  input  ping_fail_t fail_i,
  output ping_cfg_t  cfg_o,
  output logic       alert_fail_o,
  output logic       esc_fail_o
);

  ping_cfg_t        cfg_q;
  ping_fail_t       status_q, status_d;
  logic [1:0]       status_clr;
  logic             access, wr_en, addr_hit;
  logic [ApbDw-1:0] rdata;

  assign access = apb_req_i.psel & apb_req_i.penable;
  assign wr_en  = access & apb_req_i.pwrite;

  //////////////////////////////
  // read decode
  //////////////////////////////

  always_comb begin
    rdata    = '0;
    addr_hit = 1'b1;
    case (apb_req_i.paddr)
      RegCtrl:     rdata = ApbDw'(cfg_q.en);
      RegAlertEn:  rdata = ApbDw'(cfg_q.alert_en);
      RegTimeout:  rdata = ApbDw'(cfg_q.timeout_cyc);
      RegWaitMask: rdata = ApbDw'(cfg_q.wait_mask);
      RegStatus:   rdata = ApbDw'(status_q);
      default:     addr_hit = 1'b0;
    endcase
  end

  assign apb_rsp_o.prdata  = rdata;
  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.pslverr = access & ~addr_hit;

  //////////////////////////////
  // configuration
  //////////////////////////////

  // writes land at the clock edge that closes the access phase
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q <= '0;
    end else if (wr_en) begin
      case (apb_req_i.paddr)
        RegCtrl:     cfg_q.en          <= cfg_q.en | apb_req_i.pwdata[0];
        RegAlertEn:  cfg_q.alert_en    <= apb_req_i.pwdata[NAlerts-1:0];
        RegTimeout:  cfg_q.timeout_cyc <= apb_req_i.pwdata[PingCntDw-1:0];
        RegWaitMask: cfg_q.wait_mask   <= apb_req_i.pwdata[PingCntDw-1:0];
        default: ;
      endcase
    end
  end

  assign cfg_o = cfg_q;

  //////////////////////////////
  // sticky status
  //////////////////////////////

  assign status_clr = (wr_en && apb_req_i.paddr == RegStatus) ? apb_req_i.pwdata[1:0] : 2'b00;
  assign status_d   = ping_fail_t'((status_q & ~status_clr) | fail_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      status_q <= '0;
    end else begin
      status_q <= status_d;
    end
  end

  assign alert_fail_o = status_q.alert_fail;
  assign esc_fail_o   = status_q.esc_fail;

endmodule

`default_nettype wire

//--- ping_timer.sv
// ping sequencer that alternates random alert pings and round-robin
// escalation pings, each preceded by a random wait
// once enabled the FSM never returns to Init
// any redundancy mismatch or illegal state ends in FsmError for good
`timescale 1ns/1ps
`default_nettype none

module ping_timer import ping_pkg::*; (
  input  wire                clk_i,
  input  wire                rst_ni,
  input  ping_cfg_t          cfg_i,
  input  wire  [NAlerts-1:0] alert_ping_ok_i,
  input  wire  [NEscSev-1:0] esc_ping_ok_i,
  output logic [NAlerts-1:0] alert_ping_req_o,
  output logic [NEscSev-1:0] esc_ping_req_o,
  output ping_fail_t         fail_o
);

  //////////////////////////////
  // random source and counters
  //////////////////////////////

  logic                      wait_cnt_load, timeout_cnt_load, cnt_load;
  logic                      lfsr_err, cnt_err, esc_err;
  logic [PingCntDw+IdDw-1:0] lfsr_state;
  logic [IdDw-1:0]           alert_id;
  logic                      id_vld;
  ping_cnt_t                 wait_cyc, cnt_load_val, cnt_q;
  logic                      timer_expired;
  logic                      esc_cnt_en;
  esc_idx_t                  esc_idx;

  // the LFSR advances on every counter load
  assign cnt_load = wait_cnt_load | timeout_cnt_load;

  ping_lfsr u_lfsr (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .step_i  (cnt_load),
    .state_o (lfsr_state),
    .err_o   (lfsr_err)
  );

  // the alert ID holds still through a ping since no load happens there
  assign alert_id = lfsr_state[PingCntDw +: IdDw];
  assign id_vld   = cfg_i.alert_en[alert_id];

  assign wait_cyc     = (lfsr_state[PingCntDw-1:0] | MinWait) & cfg_i.wait_mask;
  assign cnt_load_val = wait_cnt_load ? wait_cyc : cfg_i.timeout_cyc;

  assign timer_expired = (cnt_q == '0);

  // shared counter for both the wait and the timeout phases
  ping_dual_reg #(
    .T        (ping_cnt_t),
    .StepMode (CntStepMode)
  ) u_cnt (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .load_i     (cnt_load),
    .load_val_i (cnt_load_val),
    .step_i     (!timer_expired),
    .q_o        (cnt_q),
    .err_o      (cnt_err)
  );

  // escalation channels are visited strictly in order
  ping_dual_reg #(
    .T        (esc_idx_t),
    .StepMode (EscStepMode)
  ) u_esc_idx (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .load_i     (1'b0),
    .load_val_i (esc_idx_t'(0)),
    .step_i     (esc_cnt_en),
    .q_o        (esc_idx),
    .err_o      (esc_err)
  );

  //////////////////////////////
  // requests and responses
  //////////////////////////////

  logic alert_ping_en, esc_ping_en;
  logic alert_ok_hit, esc_ok_hit;
  logic alert_spurious, esc_spurious;

  assign alert_ping_req_o = NAlerts'(alert_ping_en) << alert_id;
  assign esc_ping_req_o   = NEscSev'(esc_ping_en) << esc_idx;

  assign alert_ok_hit   = |(alert_ping_ok_i & alert_ping_req_o);
  assign esc_ok_hit     = |(esc_ping_ok_i & esc_ping_req_o);
  // an ok on any channel that is not being pinged fails at once
  assign alert_spurious = |(alert_ping_ok_i & ~alert_ping_req_o);
  assign esc_spurious   = |(esc_ping_ok_i & ~esc_ping_req_o);

  //////////////////////////////
  // FSM
  //////////////////////////////

  ping_state_e state_d, state_q;

  always_comb begin
    state_d           = state_q;
    wait_cnt_load     = 1'b0;
    timeout_cnt_load  = 1'b0;
    esc_cnt_en        = 1'b0;
    alert_ping_en     = 1'b0;
    esc_ping_en       = 1'b0;
    fail_o.alert_fail = alert_spurious;
    fail_o.esc_fail   = esc_spurious;

    case (state_q)
      Init: begin
        if (cfg_i.en) begin
          state_d       = AlertWait;
          wait_cnt_load = 1'b1;
        end
      end
      AlertWait: begin
        if (timer_expired) begin
          state_d          = AlertPing;
          timeout_cnt_load = 1'b1;
        end
      end
      // a masked alert ID skips the request and moves straight on
      AlertPing: begin
        alert_ping_en = id_vld;
        if (!id_vld || alert_ok_hit || timer_expired) begin
          state_d       = EscWait;
          wait_cnt_load = 1'b1;
          if (id_vld && !alert_ok_hit) begin
            fail_o.alert_fail = 1'b1;
          end
        end
      end
      EscWait: begin
        if (timer_expired) begin
          state_d          = EscPing;
          timeout_cnt_load = 1'b1;
        end
      end
      // the index advances whether the ping passed or timed out
      EscPing: begin
        esc_ping_en = 1'b1;
        if (esc_ok_hit || timer_expired) begin
          state_d       = AlertWait;
          wait_cnt_load = 1'b1;
          esc_cnt_en    = 1'b1;
          if (!esc_ok_hit) begin
            fail_o.esc_fail = 1'b1;
          end
        end
      end
      FsmError: begin
        fail_o.alert_fail = 1'b1;
        fail_o.esc_fail   = 1'b1;
      end
      default: begin
        state_d = FsmError;
      end
    endcase

    // disagreeing copies override whatever the FSM decided above
    if (lfsr_err || cnt_err || esc_err) begin
      state_d = FsmError;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Init;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

//--- ping_lfsr.sv
// tandem Galois LFSRs used as the random source of the ping timer
// both copies start from LfsrSeed after reset and are never reseeded
// state_o only exposes the low PingCntDw+IdDw bits of the first copy
`timescale 1ns/1ps
`default_nettype none

module ping_lfsr import ping_pkg::*; (
  input  wire                          clk_i,
  input  wire                          rst_ni,
  input  wire                          step_i,
  output logic [PingCntDw+IdDw-1:0]    state_o,
  output logic                         err_o
);

  logic [1:0][LfsrDw-1:0] lfsr_q;

  // one right shift of a Galois LFSR
  // the bit shifted out decides whether the tap mask is applied
  function automatic logic [LfsrDw-1:0] galois_step(input logic [LfsrDw-1:0] s);
    logic [LfsrDw-1:0] nxt;
    nxt = s >> 1;
    if (s[0]) begin
      nxt = nxt ^ LfsrTaps;
    end
    return nxt;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q[0] <= LfsrSeed;
      lfsr_q[1] <= LfsrSeed;
    end else if (step_i) begin
      lfsr_q[0] <= galois_step(lfsr_q[0]);
      lfsr_q[1] <= galois_step(lfsr_q[1]);
    end
  end

  assign state_o = lfsr_q[0][PingCntDw+IdDw-1:0];

  // an all zero state never leaves zero, so it counts as an error too
  assign err_o = (lfsr_q[0] != lfsr_q[1]) ||
                 (lfsr_q[0] == '0)        ||
                 (lfsr_q[1] == '0);

endmodule

`default_nettype wire

//--- ping_dual_reg.sv
// two copies of one value that always load or step together
// the wrap mode counts modulo NEscSev and suits small index types only
// err_o is combinational and high for as long as the copies differ
`timescale 1ns/1ps
`default_nettype none

module ping_dual_reg import ping_pkg::*; #(
  parameter type        T        = logic [PingCntDw-1:0],
  parameter step_mode_e StepMode = CntStepMode
) (
  input  wire  clk_i,
  input  wire  rst_ni,
  input  wire  load_i,
  input  T     load_val_i,
  input  wire  step_i,
  output T     q_o,
  output logic err_o
);

  T copy_q [2];

  // next value of one copy when stepping
  function automatic T step_val(input T v);
    T nxt;
    if (StepMode == StepDec) begin
      nxt = (v == '0) ? v : T'(v - 1'b1);
    end else begin
      nxt = (v >= T'(NEscSev - 1)) ? T'(0) : T'(v + 1'b1);
    end
    return nxt;
  endfunction

  // each copy computes its own next value so a glitch in one stays visible
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      copy_q[0] <= '0;
      copy_q[1] <= '0;
    end else begin
      for (int k = 0; k < 2; k++) begin
        if (load_i) begin
          copy_q[k] <= load_val_i;
        end else if (step_i) begin
          copy_q[k] <= step_val(copy_q[k]);
        end
      end
    end
  end

  assign q_o   = copy_q[0];
  assign err_o = (copy_q[0] != copy_q[1]);

endmodule

`default_nettype wire

//--- ping_pkg.sv
// shared constants, types and the register map of the ping checker
// NAlerts must equal 2**IdDw so every drawn alert ID maps to a channel
// the LFSR always starts from the same fixed seed and is never reseeded
`default_nettype none

package ping_pkg;

  //////////////////////////////
  // sizes
  //////////////////////////////

  localparam int unsigned NAlerts   = 8;
  localparam int unsigned NEscSev   = 4;
  localparam int unsigned PingCntDw = 16;
  localparam int unsigned IdDw      = 3;
  localparam int unsigned EscIdDw   = 2;
  localparam int unsigned LfsrDw    = 32;

  // x^32 + x^22 + x^2 + x + 1 written as a right shifting Galois mask
  localparam logic [LfsrDw-1:0]    LfsrSeed = 32'h5a3c_96e1;
  localparam logic [LfsrDw-1:0]    LfsrTaps = 32'h8020_0003;
  // keeps a few idle cycles between pings unless the wait mask clears them
  localparam logic [PingCntDw-1:0] MinWait  = 16'd4;

  //////////////////////////////
  // register map
  //////////////////////////////

  localparam int unsigned ApbAw = 5;
  localparam int unsigned ApbDw = 32;

  localparam logic [ApbAw-1:0] RegCtrl     = 5'h00;
  localparam logic [ApbAw-1:0] RegAlertEn  = 5'h04;
  localparam logic [ApbAw-1:0] RegTimeout  = 5'h08;
  localparam logic [ApbAw-1:0] RegWaitMask = 5'h0c;
  localparam logic [ApbAw-1:0] RegStatus   = 5'h10;

  //////////////////////////////
  // FSM and redundancy types
  //////////////////////////////

  // every pair of codes differs in at least 5 bits
  typedef enum logic [8:0] {
    Init      = 9'b000101100,
    AlertWait = 9'b011001011,
    AlertPing = 9'b110000000,
    EscWait   = 9'b101110001,
    EscPing   = 9'b011110110,
    FsmError  = 9'b100011111
  } ping_state_e;

  typedef enum logic {
    StepDec,
    StepWrapInc
  } step_mode_e;

  // the timer counts down and stops at zero
  typedef logic [PingCntDw-1:0] ping_cnt_t;
  localparam step_mode_e CntStepMode = StepDec;

  // the escalation index walks 0..NEscSev-1 and wraps
  typedef logic [EscIdDw-1:0] esc_idx_t;
  localparam step_mode_e EscStepMode = StepWrapInc;

  //////////////////////////////
  // structs
  //////////////////////////////

  typedef struct packed {
    logic                 en;
    logic [NAlerts-1:0]   alert_en;
    logic [PingCntDw-1:0] timeout_cyc;
    logic [PingCntDw-1:0] wait_mask;
  } ping_cfg_t;

  // alert_fail is the LSB so the struct lines up with the status register
  typedef struct packed {
    logic esc_fail;
    logic alert_fail;
  } ping_fail_t;

  typedef struct packed {
    logic             psel;
    logic             penable;
    logic             pwrite;
    logic [ApbAw-1:0] paddr;
    logic [ApbDw-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [ApbDw-1:0] prdata;
    logic             pready;
    logic             pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire
